//--- common/ctrlport_pkg.sv
// CtrlPort request and response structs and the response status codes
// Device DNA status word layout and the native UltraScale DNA width
package ctrlport_pkg;

  // One request from the master
  // wr and rd are one-cycle strobes, never both high together
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [19:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  // One response from a block
  // All fields stay zero while ack is low so that responses can be ORed
  typedef struct packed {
    logic        ack;
    logic [1:0]  status;
    logic [31:0] data;
  } ctrlport_resp_t;

  // Response status codes
  localparam logic [1:0] ctrl_sts_okay   = 2'd0;
  localparam logic [1:0] ctrl_sts_cmderr = 2'd1;
  localparam logic [1:0] ctrl_sts_tserr  = 2'd2;
  localparam logic [1:0] ctrl_sts_slverr = 2'd3;

  // Status word of the DNA block
  // The first field is the MSB end, so valid lands in bit 0
  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic [7:0]  bits_loaded;
    logic [6:0]  rsvd_lo;
    logic        valid;
  } dna_status_t;

  // Number of bits the UltraScale DNA port shifts out
  localparam int dna_native_width = 96;

endpackage

//--- hw/ctrlport/ctrlport_reg_ro.sv
// Read-only CtrlPort register for a packed payload of any type
// The payload is read as consecutive 32-bit words, the last one zero-padded
module ctrlport_reg_ro #(
  parameter type         value_t = logic [31:0],
  parameter logic [19:0] addr    = 20'h000
) (
  input  logic                         ctrlport_clk,
  input  logic                         rst_n,
  input  ctrlport_pkg::ctrlport_req_t  req,
  input  value_t                       value,
  output ctrlport_pkg::ctrlport_resp_t resp
);

  localparam int width     = $bits(value_t);
  localparam int num_words = (width + 31) / 32;

  logic [num_words*32-1:0] words;
  logic [19:0] offset;
  int          word_idx;
  logic        hit;

  // Place the payload at the bottom of a whole number of words
  always_comb begin
    words            = '0;
    words[width-1:0] = value;
  end

  // Byte offset from the base, only word-aligned offsets decode
  assign offset   = req.addr - addr;
  assign word_idx = int'(offset[19:2]);

  // Writes are ignored here and left to the combiner timeout
  assign hit = req.rd &&
               (req.addr >= addr) &&
               (offset[1:0] == 2'b00) &&
               (word_idx < num_words);

  // Response is registered, so the ack follows the request by one cycle
  // Every field returns to zero when there is nothing to ack
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      resp <= '0;
    end else begin
      resp <= '0;
      if (hit) begin
        resp.ack    <= 1'b1;
        resp.status <= ctrlport_pkg::ctrl_sts_okay;
        resp.data   <= words[word_idx*32 +: 32];
      end
    end
  end

endmodule

//--- hw/ctrlport/ctrlport_scratch_reg.sv
// Writable 32-bit scratch register on CtrlPort
// Writes store the data, reads return the stored value
module ctrlport_scratch_reg #(
  parameter logic [19:0] addr = 20'h020
) (
  input  logic                         ctrlport_clk,
  input  logic                         rst_n,
  input  ctrlport_pkg::ctrlport_req_t  req,
  output ctrlport_pkg::ctrlport_resp_t resp
);

  logic [31:0] scratch;
  logic        hit;

  // Only the exact address decodes
  assign hit = (req.addr == addr);

  // Register value itself
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch <= '0;
    end else if (req.wr && hit) begin
      scratch <= req.data;
    end
  end

  // Both reads and writes ack one cycle later with okay
  // Write acks carry zero data, read acks carry the value before any same-cycle write
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      resp <= '0;
    end else begin
      resp <= '0;
      if (hit && (req.wr || req.rd)) begin
        resp.ack    <= 1'b1;
        resp.status <= ctrlport_pkg::ctrl_sts_okay;
      end
      if (hit && req.rd) begin
        resp.data <= scratch;
      end
    end
  end

endmodule

//--- hw/ctrlport/ctrlport_combiner.sv
// Response combiner for CtrlPort blocks with non-overlapping address ranges
// Answers requests that no block acks with a slave error after a timeout
module ctrlport_combiner #(
  parameter int num_ports      = 2,
  parameter int timeout_cycles = 8
) (
  input  logic                         ctrlport_clk,
  input  logic                         rst_n,
  input  ctrlport_pkg::ctrlport_req_t  req,
  input  ctrlport_pkg::ctrlport_resp_t resps [num_ports],
  output ctrlport_pkg::ctrlport_resp_t resp
);

  localparam int cnt_w = $clog2(timeout_cycles + 1);

  ctrlport_pkg::ctrlport_resp_t merged;
  logic             pending;
  logic [cnt_w-1:0] cnt;
  logic             timeout_hit;

  // Idle responses are all zero, so a plain OR merges them
  always_comb begin
    merged = '0;
    for (int i = 0; i < num_ports; i++) begin
      merged = merged | resps[i];
    end
  end

  // The counter equals the number of cycles since the request cycle
  assign timeout_hit = pending && !merged.ack && (cnt == cnt_w'(timeout_cycles));

  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      cnt     <= '0;
    end else if (req.rd || req.wr) begin
      pending <= 1'b1;
      cnt     <= cnt_w'(1);
    end else if (pending) begin
      // Any ack ends the request, the timeout ack included
      if (merged.ack || timeout_hit) begin
        pending <= 1'b0;
        cnt     <= '0;
      end else begin
        cnt <= cnt + cnt_w'(1);
      end
    end
  end

  // Slave error with zero data in place of the missing block response
  always_comb begin
    resp = merged;
    if (timeout_hit) begin
      resp.ack    = 1'b1;
      resp.status = ctrlport_pkg::ctrl_sts_slverr;
      resp.data   = '0;
    end
  end

endmodule

//--- hw/dna/device_dna.sv
// Sequencer for the UltraScale serial DNA port
// Reads the port once after reset and assembles DNA value, bit count and valid flag
module device_dna #(
  parameter int dna_width = 96
) (
  input  logic                      ctrlport_clk,
  input  logic                      rst_n,
  input  logic                      dna_dout,
  output logic                      dna_read,
  output logic                      dna_shift,
  output logic [dna_width-1:0]      dna,
  output ctrlport_pkg::dna_status_t status
);

  // The start state keeps dna_read low while reset is held
  typedef enum logic [1:0] {
    st_start,
    st_read,
    st_shift,
    st_done
  } state_t;

  state_t state;
  logic [7:0] bit_cnt;
  logic [ctrlport_pkg::dna_native_width-1:0] shift_reg;
  logic last_bit;

  // The final sample is taken while the count still shows one less than the width
  assign last_bit = (bit_cnt == 8'(ctrlport_pkg::dna_native_width - 1));

  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_start;
      bit_cnt   <= '0;
      shift_reg <= '0;
    end else begin
      case (state)
        st_start: state <= st_read;
        // The port loads its value on the read strobe and shows bit 0 on dout
        st_read:  state <= st_shift;
        st_shift: begin
          // New bits enter at the top so that bit 0 ends up in the LSB
          shift_reg <= {dna_dout, shift_reg[ctrlport_pkg::dna_native_width-1:1]};
          bit_cnt   <= bit_cnt + 8'd1;
          if (last_bit) begin
            state <= st_done;
          end
        end
        // The DNA never changes, so the sequencer stays here until the next reset
        default:  state <= st_done;
      endcase
    end
  end

  // Port strobes decode straight from the state
  assign dna_read  = (state == st_read);
  assign dna_shift = (state == st_shift);

  // Keep the LSBs of a narrower DNA, zero-pad a wider one
  if (dna_width <= ctrlport_pkg::dna_native_width) begin : g_trunc
    assign dna = shift_reg[dna_width-1:0];
  end else begin : g_pad
    assign dna = {{(dna_width - ctrlport_pkg::dna_native_width){1'b0}}, shift_reg};
  end

  always_comb begin
    status             = '0;
    status.valid       = (state == st_done);
    status.bits_loaded = bit_cnt;
  end

endmodule

//--- hw/dna/device_dna_ctrlport.sv
// DNA block on CtrlPort with the DNA sequencer and two read-only registers
// DNA word reads finish with command-error status until the DNA is loaded
module device_dna_ctrlport #(
  parameter logic [19:0] dna_base_addr = 20'h000,
  parameter logic [19:0] status_addr   = 20'h010,
  parameter int          dna_width     = 96
) (
  input  logic                         ctrlport_clk,
  input  logic                         rst_n,
  input  ctrlport_pkg::ctrlport_req_t  req,
  output ctrlport_pkg::ctrlport_resp_t resp,
  output logic                         dna_read,
  output logic                         dna_shift,
  input  logic                         dna_dout
);

  logic [dna_width-1:0]         dna_value;
  ctrlport_pkg::dna_status_t    dna_status;
  ctrlport_pkg::ctrlport_resp_t dna_resp;
  ctrlport_pkg::ctrlport_resp_t status_resp;
  ctrlport_pkg::ctrlport_resp_t dna_resp_chk;

  device_dna #(
    .dna_width (dna_width)
  ) u_device_dna (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .dna_dout     (dna_dout),
    .dna_read     (dna_read),
    .dna_shift    (dna_shift),
    .dna          (dna_value),
    .status       (dna_status)
  );

  // DNA value spread over consecutive 32-bit words
  ctrlport_reg_ro #(
    .value_t (logic [dna_width-1:0]),
    .addr    (dna_base_addr)
  ) u_dna_reg (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req),
    .value        (dna_value),
    .resp         (dna_resp)
  );

  // Status word is always readable, also while loading is in progress
  ctrlport_reg_ro #(
    .value_t (ctrlport_pkg::dna_status_t),
    .addr    (status_addr)
  ) u_status_reg (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req),
    .value        (dna_status),
    .resp         (status_resp)
  );

  // Override only on an ack, an idle response must stay all zero for the OR
  always_comb begin
    dna_resp_chk = dna_resp;
    if (dna_resp.ack && !dna_status.valid) begin
      dna_resp_chk.status = ctrlport_pkg::ctrl_sts_cmderr;
    end
  end

  // Address ranges never overlap, so at most one of the two acks at a time
  assign resp = dna_resp_chk | status_resp;

endmodule

//--- hw/device_id_regs.sv
// Top level of the device identification register bank
// Connects the DNA block, the scratch register and the response combiner
module device_id_regs #(
  parameter logic [19:0] dna_base_addr  = 20'h000,
  parameter logic [19:0] status_addr    = 20'h010,
  parameter logic [19:0] scratch_addr   = 20'h020,
  parameter int          dna_width      = 96,
  parameter int          timeout_cycles = 8
) (
  input  logic                         ctrlport_clk,
  input  logic                         rst_n,
  input  ctrlport_pkg::ctrlport_req_t  req,
  output ctrlport_pkg::ctrlport_resp_t resp,
  output logic                         dna_read,
  output logic                         dna_shift,
  input  logic                         dna_dout
);

  // One response per block, index 0 is DNA and 1 is scratch
  ctrlport_pkg::ctrlport_resp_t block_resps [2];

  device_dna_ctrlport #(
    .dna_base_addr (dna_base_addr),
    .status_addr   (status_addr),
    .dna_width     (dna_width)
  ) u_dna_block (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req),
    .resp         (block_resps[0]),
    .dna_read     (dna_read),
    .dna_shift    (dna_shift),
    .dna_dout     (dna_dout)
  );

  ctrlport_scratch_reg #(
    .addr (scratch_addr)
  ) u_scratch (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req),
    .resp         (block_resps[1])
  );

  // The combiner also sees the request so it can time out unmatched ones
  ctrlport_combiner #(
    .num_ports      (2),
    .timeout_cycles (timeout_cycles)
  ) u_combiner (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req),
    .resps        (block_resps),
    .resp         (resp)
  );

endmodule

//--- tb/dna_port_model.sv
// Behavioural model of the UltraScale serial DNA port
// Loads a 96-bit value on read and shifts it out LSB first on shift
module dna_port_model (
  input  logic        clk,
  input  logic [95:0] value,
  input  logic        read,
  input  logic        shift,
  output logic        dout
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int dna_bits = 96;

  // Internal shift register of the primitive
  logic [dna_bits-1:0] shift_reg;

  // The primitive has no reset, so start from a known value until the first read
  initial begin
    shift_reg = '0;
  end

  // Read has priority over shift, as on the real port
  always @(posedge clk) begin
    if (read) begin
      shift_reg <= value;
    end else if (shift) begin
      // Zeros enter at the top once every DNA bit has gone out
      shift_reg <= {1'b0, shift_reg[dna_bits-1:1]};
    end
  end

  // Bit 0 shows on dout right after the read, before the first shift
  assign dout = shift_reg[0];

endmodule

//--- tb/device_id_regs_properties.sv
// Concurrent protocol assertions for the device identification register bank
// Bound into the top level of the design
module device_id_regs_properties (
  input logic                         ctrlport_clk,
  input logic                         rst_n,
  input ctrlport_pkg::ctrlport_req_t  req,
  input ctrlport_pkg::ctrlport_resp_t resp,
  input logic                         dna_read,
  input logic                         dna_shift
);
  timeunit 1ns;
  timeprecision 1ps;

  // Set by a request and cleared by its ack
  logic       outstanding;
  // Number of cycles with dna_read high since reset, saturating at 3
  logic [1:0] read_cycles;

  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
      read_cycles <= 2'd0;
    end else begin
      if (req.rd || req.wr) begin
        outstanding <= 1'b1;
      end else if (resp.ack) begin
        outstanding <= 1'b0;
      end
      if (dna_read && (read_cycles != 2'd3)) begin
        read_cycles <= read_cycles + 2'd1;
      end
    end
  end

  // Every ack answers a request that is still open
  ack_needs_request: assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n) resp.ack |-> outstanding
  ) else $error("ack seen with no outstanding request");

  // Acks are single-cycle pulses
  ack_single_cycle: assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n) resp.ack |=> !resp.ack
  ) else $error("ack high in two consecutive cycles");

  // The read strobe shows up once only
  read_only_once: assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n) dna_read |-> (read_cycles == 2'd0)
  ) else $error("dna_read high for more than one cycle after reset");

  // Shifting only starts once the single read has happened
  shift_after_read: assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n) dna_shift |-> (read_cycles == 2'd1)
  ) else $error("dna_shift high without exactly one preceding dna_read");

endmodule

bind device_id_regs device_id_regs_properties u_properties (
  .ctrlport_clk (ctrlport_clk),
  .rst_n        (rst_n),
  .req          (req),
  .resp         (resp),
  .dna_read     (dna_read),
  .dna_shift    (dna_shift)
);

//--- tb/device_id_regs_tb.sv
// Testbench for the device identification register bank
// Clock, reset, seeded DNA port model, transaction table, checks and watchdog
module device_id_regs_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [19:0] dna_base_addr   = 20'h000;
  localparam logic [19:0] status_addr     = 20'h010;
  localparam logic [19:0] scratch_addr    = 20'h020;
  localparam logic [19:0] unmapped_addr   = 20'h040;
  localparam int          dna_width       = 96;
  localparam int          timeout_cycles  = 8;
  localparam int          dna_bits        = 96;
  localparam int          n_entries       = 11;
  localparam int          max_polls       = 100;
  localparam int          watchdog_cycles = n_entries * (timeout_cycles + 4) + 300;

  // Bus status codes
  localparam logic [1:0] sts_okay   = 2'd0;
  localparam logic [1:0] sts_cmderr = 2'd1;
  localparam logic [1:0] sts_slverr = 2'd3;

  // One row of the transaction table
  // A poll row repeats its read until bit 0 of the returned data is set
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic        poll;
    logic        chk_data;
    logic [19:0] addr;
    logic [31:0] wdata;
    logic [1:0]  exp_status;
    logic [31:0] exp_data;
  } entry_t;

  logic                         clk;
  logic                         rst_n;
  ctrlport_pkg::ctrlport_req_t  req;
  ctrlport_pkg::ctrlport_resp_t resp;
  logic                         dna_read;
  logic                         dna_shift;
  logic                         dna_dout;
  logic [dna_bits-1:0]          dna_seeded;
  integer                       seed;
  entry_t                       entries [n_entries];

  device_id_regs #(
    .dna_base_addr  (dna_base_addr),
    .status_addr    (status_addr),
    .scratch_addr   (scratch_addr),
    .dna_width      (dna_width),
    .timeout_cycles (timeout_cycles)
  ) DUT (
    .ctrlport_clk (clk),
    .rst_n        (rst_n),
    .req          (req),
    .resp         (resp),
    .dna_read     (dna_read),
    .dna_shift    (dna_shift),
    .dna_dout     (dna_dout)
  );

  dna_port_model u_dna_port (
    .clk   (clk),
    .value (dna_seeded),
    .read  (dna_read),
    .shift (dna_shift),
    .dout  (dna_dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Ends a run that stops making progress
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Simulation timed out before the transaction table completed");
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic entry_t make_entry(
    input logic        wr,
    input logic        rd,
    input logic        poll,
    input logic        chk_data,
    input logic [19:0] addr,
    input logic [31:0] wdata,
    input logic [1:0]  exp_status,
    input logic [31:0] exp_data
  );
    entry_t e;
    e.wr         = wr;
    e.rd         = rd;
    e.poll       = poll;
    e.chk_data   = chk_data;
    e.addr       = addr;
    e.wdata      = wdata;
    e.exp_status = exp_status;
    e.exp_data   = exp_data;
    return e;
  endfunction

  // Register reads and writes answer after one cycle, unmatched requests after the timeout
  function automatic int expected_latency(input logic [1:0] status);
    if (status == sts_slverr) begin
      return timeout_cycles;
    end
    return 1;
  endfunction

  task automatic fill_table();
    logic [31:0] loaded_status;
    // Valid in bit 0, bit count in bits 15:8, all else reserved zero
    loaded_status = {16'h0000, 8'(dna_bits), 7'h00, 1'b1};
    // Bits enter the DNA register at the top, so the low word is still zero here
    entries[0]  = make_entry(0, 1, 0, 1, dna_base_addr, '0, sts_cmderr, 32'h0);
    entries[1]  = make_entry(0, 1, 0, 1, scratch_addr, '0, sts_okay, 32'h0);
    entries[2]  = make_entry(0, 1, 1, 1, status_addr, '0, sts_okay, loaded_status);
    entries[3]  = make_entry(0, 1, 0, 1, dna_base_addr, '0, sts_okay, dna_seeded[31:0]);
    entries[4]  = make_entry(0, 1, 0, 1, dna_base_addr + 20'h4, '0, sts_okay,
                             dna_seeded[63:32]);
    entries[5]  = make_entry(0, 1, 0, 1, dna_base_addr + 20'h8, '0, sts_okay,
                             dna_seeded[95:64]);
    entries[6]  = make_entry(1, 0, 0, 0, scratch_addr, 32'hA5A5_5A5A, sts_okay, 32'h0);
    entries[7]  = make_entry(0, 1, 0, 1, scratch_addr, '0, sts_okay, 32'hA5A5_5A5A);
    entries[8]  = make_entry(1, 0, 0, 1, dna_base_addr, 32'h1234_5678, sts_slverr, 32'h0);
    entries[9]  = make_entry(0, 1, 0, 1, unmapped_addr, '0, sts_slverr, 32'h0);
    entries[10] = make_entry(1, 0, 0, 1, status_addr, 32'hFFFF_FFFF, sts_slverr, 32'h0);
  endtask

  task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
  );
    if (actual !== expected) begin
      $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Drives one request for a single cycle and waits for its ack
  // Latency counts the cycles from the end of the request cycle to the ack
  task automatic issue_request(
    input  entry_t                       e,
    output ctrlport_pkg::ctrlport_resp_t rsp,
    output int                           latency
  );
    @(posedge clk);
    #1;
    req.wr   = e.wr;
    req.rd   = e.rd;
    req.addr = e.addr;
    req.data = e.wdata;
    @(posedge clk);
    #1;
    req     = '0;
    latency = 0;
    do begin
      @(negedge clk);
      latency = latency + 1;
    end while (!resp.ack);
    rsp = resp;
  endtask

  initial begin
    entry_t                       e;
    ctrlport_pkg::ctrlport_resp_t rsp;
    int                           latency;
    int                           polls;
    req   = '0;
    rst_n = 1'b0;
    seed  = 32'h357160b2;
    dna_seeded[31:0]  = $random(seed);
    dna_seeded[63:32] = $random(seed);
    dna_seeded[95:64] = $random(seed);
    fill_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < n_entries; i++) begin
      e = entries[i];
      issue_request(e, rsp, latency);
      polls = 0;
      // Each poll read is itself a plain register read
      while (e.poll && !rsp.data[0]) begin
        check_value($sformatf("resp.status (poll of entry %0d)", i),
                    32'(rsp.status), 32'(sts_okay));
        check_value($sformatf("ack latency (poll of entry %0d)", i),
                    32'(latency), 32'(1));
        polls = polls + 1;
        if (polls >= max_polls) begin
          $display("The DNA valid flag never came up after %0d status reads", polls);
          $display("TESTS FAILED");
          $fatal(1, "polling limit reached");
        end
        issue_request(e, rsp, latency);
      end
      check_value($sformatf("resp.status (entry %0d)", i),
                  32'(rsp.status), 32'(e.exp_status));
      if (e.chk_data) begin
        check_value($sformatf("resp.data (entry %0d)", i), rsp.data, e.exp_data);
      end
      check_value($sformatf("ack latency (entry %0d)", i),
                  32'(latency), 32'(expected_latency(e.exp_status)));
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verilog.f
common/ctrlport_pkg.sv
hw/ctrlport/ctrlport_reg_ro.sv
hw/ctrlport/ctrlport_scratch_reg.sv
hw/ctrlport/ctrlport_combiner.sv
hw/dna/device_dna.sv
hw/dna/device_dna_ctrlport.sv
hw/device_id_regs.sv
tb/dna_port_model.sv
tb/device_id_regs_properties.sv
tb/device_id_regs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module device_id_regs_tb -f verilog.f &&
./obj_dir/Vdevice_id_regs_tb ||
exit 1
